// File: design/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Data bits per frame. One start bit and one stop bit surround them.
    localparam int UART_DATA_W = 8;

    // One received frame as the receiver hands it out with its done pulse.
    typedef struct packed {
        logic                   framing_error;  // Stop bit sampled low.
        logic [UART_DATA_W-1:0] data;           // First bit on the line sits in bit 0.
    } uart_rx_result_t;

    // Receiver FSM states.
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,  // Waiting for a falling edge.
        RX_START = 2'd1,  // Counting up to the middle of the start bit.
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

    // Transmitter FSM states.
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

endpackage

`default_nettype wire

// File: design/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int TICK_DIVISOR = 4
) (
    input  logic i_clk,
    input  logic i_rst,
    output logic o_tick
);

    // A divisor of one still needs a one-bit counter, which then stays at zero.
    localparam int CNT_W = (TICK_DIVISOR > 1) ? $clog2(TICK_DIVISOR) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(TICK_DIVISOR - 1);

    logic [CNT_W-1:0] cnt;
    logic             tick_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt    <= '0;
            tick_q <= 1'b0;
        end else begin
            if (cnt == LAST_CNT) begin
                cnt    <= '0;
                tick_q <= 1'b1;  // Strobe lasts exactly one clock.
            end else begin
                cnt    <= cnt + 1'b1;
                tick_q <= 1'b0;
            end
        end
    end

    assign o_tick = tick_q;

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int OVERSAMPLING = 16
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_rx,
    input  logic                      i_tick,
    output uart_pkg::uart_rx_result_t o_rx_result,
    output logic                      o_rx_done
);

    import uart_pkg::*;

    localparam int TICK_W = $clog2(OVERSAMPLING);
    localparam int BIT_W  = $clog2(UART_DATA_W);

    // The start bit is checked half a bit in. Every later sample then comes one full
    // bit after the one before it, so each sample lands in the middle of its bit.
    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(OVERSAMPLING / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLING - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(UART_DATA_W - 1);

    rx_state_e              state;
    rx_state_e              state_next;
    logic [TICK_W-1:0]      tick_cnt;
    logic [TICK_W-1:0]      tick_cnt_next;
    logic [BIT_W-1:0]       bit_cnt;
    logic [BIT_W-1:0]       bit_cnt_next;
    logic [UART_DATA_W-1:0] shift_reg;
    logic [UART_DATA_W-1:0] shift_reg_next;
    uart_rx_result_t        result_q;
    uart_rx_result_t        result_next;
    logic                   done_q;
    logic                   done_next;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            result_q <= result_next;
            done_q   <= done_next;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= shift_reg_next;
    end

    always_comb begin
        state_next     = state;
        tick_cnt_next  = tick_cnt;
        bit_cnt_next   = bit_cnt;
        shift_reg_next = shift_reg;
        result_next    = result_q;
        done_next      = 1'b0;

        case (state)
            RX_IDLE: begin
                if (!i_rx) begin
                    state_next    = RX_START;
                    tick_cnt_next = '0;
                end
            end

            RX_START: begin
                if (i_tick) begin
                    if (tick_cnt == MID_TICK) begin
                        tick_cnt_next = '0;
                        if (i_rx) begin
                            state_next = RX_IDLE;  // Glitch, not a start bit.
                        end else begin
                            state_next   = RX_DATA;
                            bit_cnt_next = '0;
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end

            RX_DATA: begin
                if (i_tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        tick_cnt_next  = '0;
                        shift_reg_next = {i_rx, shift_reg[UART_DATA_W-1:1]};  // LSB first.
                        if (bit_cnt == LAST_BIT) begin
                            state_next = RX_STOP;
                        end else begin
                            bit_cnt_next = bit_cnt + 1'b1;
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end

            RX_STOP: begin
                if (i_tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        // Finishing at mid stop bit leaves half a bit to catch the next edge.
                        tick_cnt_next             = '0;
                        result_next.data          = shift_reg;
                        result_next.framing_error = ~i_rx;
                        done_next                 = 1'b1;
                        state_next                = RX_IDLE;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end

            default: begin
                state_next = RX_IDLE;
            end
        endcase
    end

    assign o_rx_result = result_q;
    assign o_rx_done   = done_q;

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int OVERSAMPLING = 16
) (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_tick,
    input  logic                             i_tx_start,
    input  logic [uart_pkg::UART_DATA_W-1:0] i_tx_data,
    output logic                             o_tx,
    output logic                             o_tx_busy,
    output logic                             o_tx_done
);

    import uart_pkg::*;

    localparam int TICK_W = $clog2(OVERSAMPLING);
    localparam int BIT_W  = $clog2(UART_DATA_W);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLING - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(UART_DATA_W - 1);

    tx_state_e              state;
    tx_state_e              state_next;
    logic [TICK_W-1:0]      tick_cnt;
    logic [TICK_W-1:0]      tick_cnt_next;
    logic [BIT_W-1:0]       bit_cnt;
    logic [BIT_W-1:0]       bit_cnt_next;
    logic [UART_DATA_W-1:0] shift_reg;
    logic [UART_DATA_W-1:0] shift_reg_next;
    logic                   tx_q;
    logic                   tx_next;
    logic                   done_q;
    logic                   done_next;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_q     <= 1'b1;  // Line idles high.
            done_q   <= 1'b0;
        end else begin
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            tx_q     <= tx_next;
            done_q   <= done_next;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= shift_reg_next;
    end

    always_comb begin
        state_next     = state;
        tick_cnt_next  = tick_cnt;
        bit_cnt_next   = bit_cnt;
        shift_reg_next = shift_reg;
        tx_next        = tx_q;
        done_next      = 1'b0;

        case (state)
            TX_IDLE: begin
                tx_next = 1'b1;
                if (i_tx_start) begin
                    state_next     = TX_START;
                    tick_cnt_next  = '0;
                    shift_reg_next = i_tx_data;
                    tx_next        = 1'b0;  // Start bit goes out right away.
                end
            end

            TX_START: begin
                if (i_tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        state_next    = TX_DATA;
                        tick_cnt_next = '0;
                        bit_cnt_next  = '0;
                        tx_next       = shift_reg[0];
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end

            TX_DATA: begin
                if (i_tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        tick_cnt_next  = '0;
                        shift_reg_next = {1'b0, shift_reg[UART_DATA_W-1:1]};
                        if (bit_cnt == LAST_BIT) begin
                            state_next = TX_STOP;
                            tx_next    = 1'b1;
                        end else begin
                            bit_cnt_next = bit_cnt + 1'b1;
                            tx_next      = shift_reg[1];  // Next bit before the shift lands.
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end

            TX_STOP: begin
                if (i_tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        state_next    = TX_IDLE;
                        tick_cnt_next = '0;
                        done_next     = 1'b1;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end

            default: begin
                state_next = TX_IDLE;
                tx_next    = 1'b1;
            end
        endcase
    end

    assign o_tx      = tx_q;
    assign o_tx_busy = (state != TX_IDLE);  // Start pulses are dropped while this is high.
    assign o_tx_done = done_q;

endmodule

`default_nettype wire

// File: design/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core #(
    parameter int OVERSAMPLING = 16,
    parameter int TICK_DIVISOR = 4
) (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_rx,
    input  logic                             i_tx_start,
    input  logic [uart_pkg::UART_DATA_W-1:0] i_tx_data,
    output logic                             o_tx,
    output logic                             o_tx_busy,
    output logic                             o_tx_done,
    output logic                             o_rx_done,
    output uart_pkg::uart_rx_result_t        o_rx_result
);

    logic tick;  // One strobe drives both directions.

    baud_tick_gen #(
        .TICK_DIVISOR (TICK_DIVISOR)
    ) u_tick (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .o_tick (tick)
    );

    // The serial input is expected to be synchronized to i_clk already.
    uart_rx #(
        .OVERSAMPLING (OVERSAMPLING)
    ) u_rx (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rx        (i_rx),
        .i_tick      (tick),
        .o_rx_result (o_rx_result),
        .o_rx_done   (o_rx_done)
    );

    uart_tx #(
        .OVERSAMPLING (OVERSAMPLING)
    ) u_tx (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_tick     (tick),
        .i_tx_start (i_tx_start),
        .i_tx_data  (i_tx_data),
        .o_tx       (o_tx),
        .o_tx_busy  (o_tx_busy),
        .o_tx_done  (o_tx_done)
    );

endmodule

`default_nettype wire

// File: verification/uart_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core_assertions #(
    parameter int OVERSAMPLING = 16,
    parameter int TICK_DIVISOR = 4
) (
    input logic                i_clk,
    input logic                i_rst,
    input logic                i_tx_start,
    input logic                i_tx,
    input logic                i_tx_busy,
    input logic                i_tx_done,
    input logic                i_rx_done,
    input uart_pkg::rx_state_e i_rx_state
);

    import uart_pkg::*;

    // The start check comes half a bit after the edge, give or take one tick.
    localparam int START_MAX_CLKS = (OVERSAMPLING / 2 + 1) * TICK_DIVISOR;

    rx_done_single: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rx_done |=> !i_rx_done)
        else $error("o_rx_done stayed high for more than one cycle");

    tx_done_single: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tx_done |=> !i_tx_done)
        else $error("o_tx_done stayed high for more than one cycle");

    // The line may only leave the idle level inside a frame.
    tx_idle_high: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_tx_busy |-> i_tx)
        else $error("o_tx was low while the transmitter was idle");

    busy_needs_start: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_tx_busy) |-> $past(i_tx_start))
        else $error("o_tx_busy rose without a start pulse in the previous cycle");

    rx_start_bounded: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_rx_state == RX_START) |-> ##[1:START_MAX_CLKS] (i_rx_state != RX_START))
        else $error("The receiver stayed in RX_START for longer than half a bit");

endmodule

bind uart_core uart_core_assertions #(
    .OVERSAMPLING (OVERSAMPLING),
    .TICK_DIVISOR (TICK_DIVISOR)
) u_assertions (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_tx_start (i_tx_start),
    .i_tx       (o_tx),
    .i_tx_busy  (o_tx_busy),
    .i_tx_done  (o_tx_done),
    .i_rx_done  (o_rx_done),
    .i_rx_state (u_rx.state)
);

`default_nettype wire

// File: verification/tb_uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_core;

    import uart_pkg::*;

    localparam int OVERSAMPLING  = 16;
    localparam int TICK_DIVISOR  = 4;
    localparam int BIT_CLKS      = OVERSAMPLING * TICK_DIVISOR;
    localparam int NUM_ROWS      = 11;
    localparam int TIMEOUT_CLKS  = NUM_ROWS * 12 * BIT_CLKS + 200;
    localparam int MIN_BUSY_CLKS = 10 * BIT_CLKS - TICK_DIVISOR;

    typedef enum logic {MODE_SERIAL, MODE_LOOP} mode_e;

    typedef struct packed {
        mode_e                  mode;
        logic                   rand_byte;    // Byte is drawn from $random at run time.
        logic [UART_DATA_W-1:0] data;
        logic                   stop_level;
        logic [7:0]             glitch_clks;
        logic                   no_gap;       // Next frame follows the stop bit directly.
        logic                   retrigger;    // Second start pulse while busy.
        logic [UART_DATA_W-1:0] exp_data;
        logic                   exp_fe;
    } test_row_t;

    logic                   i_clk;
    logic                   i_rst;
    logic                   rx_line;
    logic                   rx_sel;
    logic                   dut_rx;
    logic                   i_tx_start;
    logic [UART_DATA_W-1:0] i_tx_data;
    logic                   o_tx;
    logic                   o_tx_busy;
    logic                   o_tx_done;
    logic                   o_rx_done;
    uart_rx_result_t        o_rx_result;

    test_row_t       rows [NUM_ROWS];
    string           names [NUM_ROWS];
    uart_rx_result_t rx_results [$];
    int              tx_done_total = 0;
    int              busy_total = 0;
    int              cycle_cnt = 0;
    int              errors = 0;
    integer          seed;

    assign dut_rx = rx_sel ? o_tx : rx_line;  // Loopback select.

    uart_core #(
        .OVERSAMPLING (OVERSAMPLING),
        .TICK_DIVISOR (TICK_DIVISOR)
    ) u_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rx        (dut_rx),
        .i_tx_start  (i_tx_start),
        .i_tx_data   (i_tx_data),
        .o_tx        (o_tx),
        .o_tx_busy   (o_tx_busy),
        .o_tx_done   (o_tx_done),
        .o_rx_done   (o_rx_done),
        .o_rx_result (o_rx_result)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (o_rx_done) begin
                rx_results.push_back(o_rx_result);
            end
            if (o_tx_done) begin
                tx_done_total <= tx_done_total + 1;
            end
            if (o_tx_busy) begin
                busy_total <= busy_total + 1;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CLKS) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CLKS);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic drive_bit(input logic level, input int clks);
        @(posedge i_clk);
        rx_line <= level;
        repeat (clks - 1) @(posedge i_clk);
    endtask

    task automatic drive_frame(input logic [UART_DATA_W-1:0] data, input logic stop_level);
        int b;
        drive_bit(1'b0, BIT_CLKS);
        for (b = 0; b < UART_DATA_W; b++) begin
            drive_bit(data[b], BIT_CLKS);
        end
        if (stop_level) begin
            drive_bit(1'b1, BIT_CLKS);
        end else begin
            // Low past the middle sample only, so the tail is not read as a new start bit.
            drive_bit(1'b0, BIT_CLKS / 2 + 8);
            drive_bit(1'b1, BIT_CLKS / 2 - 8);
        end
    endtask

    task automatic check_rx(input int idx);
        uart_rx_result_t got;
        int              n;
        n = 0;
        while (rx_results.size() == 0 && n < 3 * BIT_CLKS) begin
            @(negedge i_clk);
            n++;
        end
        assert (rx_results.size() == 1) else begin
            $display("ERR %s frame count: expected 1 actual %0d", names[idx], rx_results.size());
            errors++;
        end
        if (rx_results.size() > 0) begin
            got = rx_results.pop_front();
            assert (got.data == rows[idx].exp_data) else begin
                $display("ERR %s data: expected %02h actual %02h",
                         names[idx], rows[idx].exp_data, got.data);
                errors++;
            end
            assert (got.framing_error == rows[idx].exp_fe) else begin
                $display("ERR %s framing_error: expected %0b actual %0b",
                         names[idx], rows[idx].exp_fe, got.framing_error);
                errors++;
            end
        end
        rx_results.delete();
    endtask

    task automatic run_serial(input int idx);
        if (rows[idx].glitch_clks != 0) begin
            drive_bit(1'b0, rows[idx].glitch_clks);
            drive_bit(1'b1, 2 * BIT_CLKS);
            assert (rx_results.size() == 0) else begin
                $display("%s: the receiver reported a frame after a short glitch", names[idx]);
                errors++;
            end
            rx_results.delete();
        end
        drive_frame(rows[idx].data, rows[idx].stop_level);
        check_rx(idx);
        if (!rows[idx].no_gap) begin
            drive_bit(1'b1, BIT_CLKS);
        end
    endtask

    task automatic run_loopback(input int idx);
        int done_base;
        int busy_base;
        int n;
        @(posedge i_clk);
        rx_sel    <= 1'b1;
        done_base = tx_done_total;
        busy_base = busy_total;
        @(posedge i_clk);
        i_tx_start <= 1'b1;
        i_tx_data  <= rows[idx].data;
        @(posedge i_clk);
        i_tx_start <= 1'b0;
        if (rows[idx].retrigger) begin
            repeat (3 * BIT_CLKS) @(posedge i_clk);
            i_tx_start <= 1'b1;
            i_tx_data  <= ~rows[idx].data;
            @(posedge i_clk);
            i_tx_start <= 1'b0;
        end
        n = 0;
        while (tx_done_total == done_base && n < 12 * BIT_CLKS) begin
            @(negedge i_clk);
            n++;
        end
        assert (tx_done_total != done_base) else begin
            $display("%s: the transmitter never signalled the end of its frame", names[idx]);
            errors++;
        end
        repeat (BIT_CLKS) @(negedge i_clk);
        assert (tx_done_total - done_base == 1) else begin
            $display("ERR %s tx_done count: expected 1 actual %0d",
                     names[idx], tx_done_total - done_base);
            errors++;
        end
        check_rx(idx);
        if (rows[idx].retrigger) begin
            assert (busy_total - busy_base >= MIN_BUSY_CLKS) else begin
                $display("ERR %s busy cycles: expected at least %0d actual %0d",
                         names[idx], MIN_BUSY_CLKS, busy_total - busy_base);
                errors++;
            end
            assert (!o_tx_busy) else begin
                $display("%s: the start pulse sent while busy started another frame", names[idx]);
                errors++;
            end
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          idx;
        int          errs_before;
        int          failed;
        i_rst      = 1'b1;
        rx_line    = 1'b1;
        rx_sel     = 1'b0;
        i_tx_start = 1'b0;
        i_tx_data  = '0;
        seed       = 32'h4139828e;
        failed     = 0;

        names[0]  = "byte_00";
        rows[0]   = '{MODE_SERIAL, 1'b0, 8'h00, 1'b1, 8'd0,  1'b0, 1'b0, 8'h00, 1'b0};
        names[1]  = "byte_ff";
        rows[1]   = '{MODE_SERIAL, 1'b0, 8'hFF, 1'b1, 8'd0,  1'b0, 1'b0, 8'hFF, 1'b0};
        names[2]  = "byte_a5";
        rows[2]   = '{MODE_SERIAL, 1'b0, 8'hA5, 1'b1, 8'd0,  1'b0, 1'b0, 8'hA5, 1'b0};
        names[3]  = "random_0";
        rows[3]   = '{MODE_SERIAL, 1'b1, 8'h00, 1'b1, 8'd0,  1'b0, 1'b0, 8'h00, 1'b0};
        names[4]  = "random_1";
        rows[4]   = '{MODE_SERIAL, 1'b1, 8'h00, 1'b1, 8'd0,  1'b0, 1'b0, 8'h00, 1'b0};
        names[5]  = "stop_low";
        rows[5]   = '{MODE_SERIAL, 1'b0, 8'h5A, 1'b0, 8'd0,  1'b0, 1'b0, 8'h5A, 1'b1};
        names[6]  = "glitch";
        rows[6]   = '{MODE_SERIAL, 1'b0, 8'h96, 1'b1, 8'd20, 1'b0, 1'b0, 8'h96, 1'b0};
        names[7]  = "b2b_first";
        rows[7]   = '{MODE_SERIAL, 1'b0, 8'h3C, 1'b1, 8'd0,  1'b1, 1'b0, 8'h3C, 1'b0};
        names[8]  = "b2b_second";
        rows[8]   = '{MODE_SERIAL, 1'b0, 8'hC3, 1'b1, 8'd0,  1'b0, 1'b0, 8'hC3, 1'b0};
        names[9]  = "loopback";
        rows[9]   = '{MODE_LOOP,   1'b0, 8'h6B, 1'b1, 8'd0,  1'b0, 1'b0, 8'h6B, 1'b0};
        names[10] = "retrigger";
        rows[10]  = '{MODE_LOOP,   1'b0, 8'hD2, 1'b1, 8'd0,  1'b0, 1'b1, 8'hD2, 1'b0};

        for (idx = 0; idx < NUM_ROWS; idx++) begin
            if (rows[idx].rand_byte) begin
                rnd                = $random(seed);
                rows[idx].data     = rnd[UART_DATA_W-1:0];
                rows[idx].exp_data = rnd[UART_DATA_W-1:0];
            end
        end

        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (BIT_CLKS) @(posedge i_clk);

        for (idx = 0; idx < NUM_ROWS; idx++) begin
            errs_before = errors;
            if (rows[idx].mode == MODE_SERIAL) begin
                run_serial(idx);
            end else begin
                run_loopback(idx);
            end
            if (errors == errs_before) begin
                $display("%-12s pass", names[idx]);
            end else begin
                $display("%-12s FAIL", names[idx]);
                failed++;
            end
        end

        $display("%0d tests run, %0d failed, %0d errors", NUM_ROWS, failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/uart_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_core.sv
verification/uart_core_assertions.sv
verification/tb_uart_core.sv
